/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := core_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
source/core_pkg.sv
source/fetch_stage.sv
source/decoder.sv
source/regfile.sv
source/id_stage.sv
source/ex_stage.sv
source/core_top.sv
tests/core_assert.sv
tests/core_tb.sv

/* source/core_pkg.sv */
// ----------------------------------------
// Core package
// Widths, opcode and ALU enums and the
// structs passed between pipeline stages
// ----------------------------------------
package core_pkg;

    // ----------------------------------------
    // Widths fixed by the ISA
    // ----------------------------------------
    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes known to the decoder
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOP
    } alu_op_t;

    // Instruction request FSM
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT
    } fetch_state_t;

    // ----------------------------------------
    // Pipeline structs
    // ----------------------------------------
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
    } fetch_t;

    typedef struct packed {
        alu_op_t               op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [XLEN-1:0]       pc;
    } issue_t;

    // Retired instruction, also used for forwarding
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       wdata;
    } commit_t;

endpackage

/* source/core_top.sv */
// ----------------------------------------
// Core top level
// Fetch, decode/issue and execute/commit
// with the registered fetch enable
// ----------------------------------------
`timescale 1ns/100ps

module core_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      fetch_enable_i,
    input  logic [core_pkg::XLEN-1:0] boot_addr_i,
    // Instruction port
    output logic                      instr_req_o,
    output logic [core_pkg::XLEN-1:0] instr_addr_o,
    input  logic                      instr_gnt_i,
    input  logic                      instr_rvalid_i,
    input  logic [core_pkg::ILEN-1:0] instr_rdata_i,
    output logic                      core_busy_o,
    // Retired instructions
    output logic                      commit_valid_o,
    output core_pkg::commit_t         commit_o
);

    logic              fetch_en_q;
    logic              fetch_busy;
    logic              fetch_valid;
    core_pkg::fetch_t  fetch;
    logic              issue_valid;
    core_pkg::issue_t  issue;
    core_pkg::commit_t fwd_ex;
    logic              fwd_valid;
    logic              commit_valid;
    core_pkg::commit_t commit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_en_q <= 1'b0;
        end else begin
            fetch_en_q <= fetch_enable_i;
        end
    end

    // ----------------------------------------
    // Pipeline
    // ----------------------------------------
    fetch_stage fetch_stage_inst (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_en_i     ( fetch_en_q     ),
        .boot_addr_i    ( boot_addr_i    ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .fetch_valid_o  ( fetch_valid    ),
        .fetch_o        ( fetch          ),
        .busy_o         ( fetch_busy     )
    );

    id_stage id_stage_inst (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .fetch_valid_i  ( fetch_valid  ),
        .fetch_i        ( fetch        ),
        .fwd_ex_i       ( fwd_ex       ),
        .commit_valid_i ( commit_valid ),
        .commit_i       ( commit       ),
        .issue_valid_o  ( issue_valid  ),
        .issue_o        ( issue        )
    );

    ex_stage ex_stage_inst (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .issue_valid_i  ( issue_valid  ),
        .issue_i        ( issue        ),
        .fwd_o          ( fwd_ex       ),
        .fwd_valid_o    ( fwd_valid    ),
        .commit_valid_o ( commit_valid ),
        .commit_o       ( commit       )
    );

    // Busy while fetching or anything in flight
    assign core_busy_o    = fetch_busy | fetch_valid | fwd_valid | commit_valid;
    assign commit_valid_o = commit_valid;
    assign commit_o       = commit;

endmodule

/* source/decoder.sv */
// ----------------------------------------
// Instruction decoder
// Maps an RV32 word onto an ALU operation,
// register indices and an I-type immediate
// ----------------------------------------
`timescale 1ns/100ps

module decoder (
    input  logic [core_pkg::ILEN-1:0]       instr_i,
    output core_pkg::alu_op_t               op_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic                            we_o,
    output logic                            use_imm_o,
    output logic [core_pkg::XLEN-1:0]       imm_o
);

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    core_pkg::opcode_t opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;

    assign opcode = core_pkg::opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rd_o  = instr_i[11:7];
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    // Sign-extended I-type immediate
    assign imm_o = {{(core_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        op_o      = core_pkg::ALU_NOP;
        we_o      = 1'b0;
        use_imm_o = 1'b0;
        case (opcode)
            // Only addi in the immediate group
            core_pkg::OPC_OP_IMM: begin
                if (funct3 == F3_ADD) begin
                    op_o      = core_pkg::ALU_ADD;
                    we_o      = 1'b1;
                    use_imm_o = 1'b1;
                end
            end
            core_pkg::OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    we_o = 1'b1;
                    case (funct3)
                        F3_ADD:  op_o = core_pkg::ALU_ADD;
                        F3_XOR:  op_o = core_pkg::ALU_XOR;
                        F3_OR:   op_o = core_pkg::ALU_OR;
                        F3_AND:  op_o = core_pkg::ALU_AND;
                        default: we_o = 1'b0;
                    endcase
                end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    op_o = core_pkg::ALU_SUB;
                    we_o = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* source/ex_stage.sv */
// ----------------------------------------
// Execute stage
// ALU on the issue register and the commit
// register driving write-back
// ----------------------------------------
`timescale 1ns/100ps

module ex_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              issue_valid_i,
    input  core_pkg::issue_t  issue_i,
    output core_pkg::commit_t fwd_o,
    output logic              fwd_valid_o,
    output logic              commit_valid_o,
    output core_pkg::commit_t commit_o
);

    logic [core_pkg::XLEN-1:0] alu_result;
    logic                      commit_valid_q;
    core_pkg::commit_t         commit_q;

    always_comb begin
        case (issue_i.op)
            core_pkg::ALU_ADD: alu_result = issue_i.operand_a + issue_i.operand_b;
            core_pkg::ALU_SUB: alu_result = issue_i.operand_a - issue_i.operand_b;
            core_pkg::ALU_AND: alu_result = issue_i.operand_a & issue_i.operand_b;
            core_pkg::ALU_OR:  alu_result = issue_i.operand_a | issue_i.operand_b;
            core_pkg::ALU_XOR: alu_result = issue_i.operand_a ^ issue_i.operand_b;
            default:           alu_result = '0;
        endcase
    end

    // In-flight result, write enable dropped for x0 or empty slot
    assign fwd_o.pc    = issue_i.pc;
    assign fwd_o.rd    = issue_i.rd;
    assign fwd_o.we    = issue_valid_i && issue_i.we && (issue_i.rd != '0);
    assign fwd_o.wdata = alu_result;
    assign fwd_valid_o = issue_valid_i;

    // Commit register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= issue_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            commit_q <= fwd_o;
        end
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_o       = commit_q;

endmodule

/* source/fetch_stage.sv */
// ----------------------------------------
// Fetch stage
// PC generation, req/gnt/rvalid request FSM
// and the fetched-instruction register
// ----------------------------------------
`timescale 1ns/100ps

module fetch_stage (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           fetch_en_i,
    input  logic [core_pkg::XLEN-1:0]      boot_addr_i,
    // Instruction port
    output logic                           instr_req_o,
    output logic [core_pkg::XLEN-1:0]      instr_addr_o,
    input  logic                           instr_gnt_i,
    input  logic                           instr_rvalid_i,
    input  logic [core_pkg::ILEN-1:0]      instr_rdata_i,
    // To decode
    output logic                           fetch_valid_o,
    output core_pkg::fetch_t               fetch_o,
    output logic                           busy_o
);

    core_pkg::fetch_state_t         state_q, state_d;
    logic [core_pkg::XLEN-1:0]      pc_q;
    logic [core_pkg::XLEN-1:0]      addr_q;
    logic                           fetch_valid_q;
    core_pkg::fetch_t               fetch_q;
    logic                           granted;
    logic                           returned;

    assign instr_req_o  = (state_q == core_pkg::FETCH_REQ);
    assign instr_addr_o = pc_q;
    assign granted      = instr_req_o && instr_gnt_i;
    assign returned     = (state_q == core_pkg::FETCH_WAIT) && instr_rvalid_i;

    // ----------------------------------------
    // Request FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            core_pkg::FETCH_IDLE: begin
                if (fetch_en_i) begin
                    state_d = core_pkg::FETCH_REQ;
                end
            end
            // Hold req and address until granted
            core_pkg::FETCH_REQ: begin
                if (instr_gnt_i) begin
                    state_d = core_pkg::FETCH_WAIT;
                end
            end
            core_pkg::FETCH_WAIT: begin
                if (instr_rvalid_i) begin
                    state_d = fetch_en_i ? core_pkg::FETCH_REQ : core_pkg::FETCH_IDLE;
                end
            end
            default: state_d = core_pkg::FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= core_pkg::FETCH_IDLE;
            pc_q          <= '0;
            fetch_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            fetch_valid_q <= returned;
            // Boot address is taken while idle and disabled
            if (state_q == core_pkg::FETCH_IDLE && !fetch_en_i) begin
                pc_q <= boot_addr_i;
            end else if (granted) begin
                pc_q <= pc_q + core_pkg::XLEN'(4);
            end
        end
    end

    // Granted address and returned word
    always_ff @(posedge clk_i) begin
        if (granted) begin
            addr_q <= pc_q;
        end
        if (returned) begin
            fetch_q.pc    <= addr_q;
            fetch_q.instr <= instr_rdata_i;
        end
    end

    assign fetch_valid_o = fetch_valid_q;
    assign fetch_o       = fetch_q;
    assign busy_o        = (state_q != core_pkg::FETCH_IDLE);

endmodule

/* source/id_stage.sv */
// ----------------------------------------
// Decode and issue stage
// Operand read with bypassing from execute
// and commit, then the issue register
// ----------------------------------------
`timescale 1ns/100ps

module id_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              fetch_valid_i,
    input  core_pkg::fetch_t  fetch_i,
    input  core_pkg::commit_t fwd_ex_i,
    input  logic              commit_valid_i,
    input  core_pkg::commit_t commit_i,
    output logic              issue_valid_o,
    output core_pkg::issue_t  issue_o
);

    core_pkg::alu_op_t               op;
    logic [core_pkg::REG_ADDR_W-1:0] rd, rs1, rs2;
    logic                            we, use_imm;
    logic [core_pkg::XLEN-1:0]       imm;
    logic [core_pkg::XLEN-1:0]       rf_a, rf_b;
    logic [core_pkg::XLEN-1:0]       operand_a, operand_b;
    logic                            issue_valid_q;
    core_pkg::issue_t                issue_q;

    // Youngest producer wins, x0 is always zero
    function automatic logic [core_pkg::XLEN-1:0] select_operand(
        input logic [core_pkg::REG_ADDR_W-1:0] rs,
        input logic [core_pkg::XLEN-1:0]       rf_data,
        input core_pkg::commit_t               ex_res,
        input logic                            cm_valid,
        input core_pkg::commit_t               cm_res
    );
        if (rs == '0) begin
            return '0;
        end
        if (ex_res.we && ex_res.rd == rs) begin
            return ex_res.wdata;
        end
        if (cm_valid && cm_res.we && cm_res.rd == rs) begin
            return cm_res.wdata;
        end
        return rf_data;
    endfunction

    decoder decoder_inst (
        .instr_i   ( fetch_i.instr ),
        .op_o      ( op            ),
        .rd_o      ( rd            ),
        .rs1_o     ( rs1           ),
        .rs2_o     ( rs2           ),
        .we_o      ( we            ),
        .use_imm_o ( use_imm       ),
        .imm_o     ( imm           )
    );

    // Commit register doubles as write port
    regfile regfile_inst (
        .clk_i     ( clk_i                        ),
        .rst_ni    ( rst_ni                       ),
        .raddr_a_i ( rs1                          ),
        .raddr_b_i ( rs2                          ),
        .rdata_a_o ( rf_a                         ),
        .rdata_b_o ( rf_b                         ),
        .we_i      ( commit_valid_i && commit_i.we ),
        .waddr_i   ( commit_i.rd                  ),
        .wdata_i   ( commit_i.wdata               )
    );

    assign operand_a = select_operand(rs1, rf_a, fwd_ex_i, commit_valid_i, commit_i);
    assign operand_b = use_imm ? imm
                               : select_operand(rs2, rf_b, fwd_ex_i, commit_valid_i, commit_i);

    // ----------------------------------------
    // Issue register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i) begin
            issue_q.op        <= op;
            issue_q.rd        <= rd;
            issue_q.we        <= we;
            issue_q.operand_a <= operand_a;
            issue_q.operand_b <= operand_b;
            issue_q.pc        <= fetch_i.pc;
        end
    end

    assign issue_valid_o = issue_valid_q;
    assign issue_o       = issue_q;

endmodule

/* source/regfile.sv */
// ----------------------------------------
// Register file
// 31 flip-flop registers, x0 tied to zero
// ----------------------------------------
`timescale 1ns/100ps

module regfile (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [core_pkg::XLEN-1:0]       rdata_a_o,
    output logic [core_pkg::XLEN-1:0]       rdata_b_o,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i
);

    logic [core_pkg::XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 never stored
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* tests/core_assert.sv */
// ----------------------------------------
// Core protocol assertions
// Instruction port, commit order and
// pipeline latency, bound into core_top
// ----------------------------------------
`timescale 1ns/100ps

module core_assert (
    input logic                      clk_i,
    input logic                      rst_ni,
    input logic                      fetch_en_i,
    input logic [core_pkg::XLEN-1:0] boot_addr_i,
    input logic                      instr_req_i,
    input logic [core_pkg::XLEN-1:0] instr_addr_i,
    input logic                      instr_gnt_i,
    input logic                      instr_rvalid_i,
    input core_pkg::fetch_state_t    fetch_state_i,
    input logic                      core_busy_i,
    input logic                      commit_valid_i,
    input core_pkg::commit_t         commit_i
);

    logic                      gnt_seen_q;
    logic [core_pkg::XLEN-1:0] gnt_addr_q;
    logic                      commit_seen_q;
    logic [core_pkg::XLEN-1:0] commit_pc_q;
    logic [core_pkg::XLEN-1:0] next_gnt_addr;
    logic [core_pkg::XLEN-1:0] next_commit_pc;
    logic                      handshake;

    assign handshake      = instr_req_i && instr_gnt_i;
    assign next_gnt_addr  = gnt_seen_q ? gnt_addr_q + 32'd4 : boot_addr_i;
    assign next_commit_pc = commit_seen_q ? commit_pc_q + 32'd4 : boot_addr_i;

    // Last granted address and last committed pc
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_seen_q    <= 1'b0;
            gnt_addr_q    <= '0;
            commit_seen_q <= 1'b0;
            commit_pc_q   <= '0;
        end else begin
            if (handshake) begin
                gnt_seen_q <= 1'b1;
                gnt_addr_q <= instr_addr_i;
            end
            if (commit_valid_i) begin
                commit_seen_q <= 1'b1;
                commit_pc_q   <= commit_i.pc;
            end
        end
    end

    // ----------------------------------------
    // Properties
    // ----------------------------------------
    idle_before_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !fetch_en_i |-> !instr_req_i && !commit_valid_i && !core_busy_i)
        else $error("core active before fetch enable");

    busy_level: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_req_i || commit_valid_i || fetch_state_i == core_pkg::FETCH_WAIT
        |-> core_busy_i)
        else $error("core not busy while a request or commit is in flight");

    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
        else $error("request dropped or address changed before grant");

    gnt_addr_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        handshake |-> instr_addr_i == next_gnt_addr)
        else $error("granted address out of sequence");

    rvalid_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_rvalid_i |-> fetch_state_i == core_pkg::FETCH_WAIT)
        else $error("rvalid without an outstanding request");

    commit_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_valid_i |-> commit_i.pc == next_commit_pc)
        else $error("commit pc out of program order");

    x0_no_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_valid_i && commit_i.rd == '0 |-> !commit_i.we)
        else $error("commit to x0 with write enable");

    commit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_valid_i == $past(instr_rvalid_i, 3))
        else $error("commit not three cycles after rvalid");

endmodule

bind core_top core_assert core_assert_inst (
    .clk_i          ( clk_i                    ),
    .rst_ni         ( rst_ni                   ),
    .fetch_en_i     ( fetch_en_q               ),
    .boot_addr_i    ( boot_addr_i              ),
    .instr_req_i    ( instr_req_o              ),
    .instr_addr_i   ( instr_addr_o             ),
    .instr_gnt_i    ( instr_gnt_i              ),
    .instr_rvalid_i ( instr_rvalid_i           ),
    .fetch_state_i  ( fetch_stage_inst.state_q ),
    .core_busy_i    ( core_busy_o              ),
    .commit_valid_i ( commit_valid_o           ),
    .commit_i       ( commit_o                 )
);

/* tests/core_tb.sv */
// ----------------------------------------
// Core testbench
// Random instruction memory on the req/gnt/rvalid
// port and a shadow register file model
// ----------------------------------------
`timescale 1ns/100ps

module core_tb;

    localparam int          NUM_COMMITS    = 200;
    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_CYCLES = NUM_COMMITS * 10 + RESET_CYCLES;
    localparam logic [31:0] BOOT_ADDR      = 32'h0000_1000;

    // RV32 encodings used by the memory model and the reference model
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    logic              clk_i;
    logic              rst_ni;
    logic              fetch_enable_i;
    logic [31:0]       boot_addr_i;
    logic              instr_req_o;
    logic [31:0]       instr_addr_o;
    logic              instr_gnt_i    = 1'b0;
    logic              instr_rvalid_i = 1'b0;
    logic [31:0]       instr_rdata_i  = '0;
    logic              core_busy_o;
    logic              commit_valid_o;
    core_pkg::commit_t commit_o;

    integer      seed       = 72965;
    logic [31:0] imem [logic [31:0]];
    logic [31:0] shadow [0:31];
    logic [31:0] pend_addr  = '0;
    logic        rv_pending = 1'b0;
    logic [1:0]  rv_cnt     = '0;
    logic [1:0]  gnt_cnt    = '0;
    int          commit_cnt = 0;
    int          cycle_cnt  = 0;

    core_top core_top_inst (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_enable_i ( fetch_enable_i ),
        .boot_addr_i    ( boot_addr_i    ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .core_busy_o    ( core_busy_o    ),
        .commit_valid_o ( commit_valid_o ),
        .commit_o       ( commit_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        rst_ni         = 1'b0;
        fetch_enable_i = 1'b0;
        boot_addr_i    = BOOT_ADDR;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        fetch_enable_i <= 1'b1;
    end

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        fail_run();
    endtask

    // Mostly supported ALU ops on x0..x7 so that neighbours depend on each other
    function automatic logic [31:0] gen_word();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        r   = $unsigned($random(seed));
        rd  = {2'b00, r[6:4]};
        rs1 = {2'b00, r[9:7]};
        rs2 = {2'b00, r[12:10]};
        imm = r[24:13];
        case (r[3:0])
            4'd3, 4'd4:   return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
            4'd5, 4'd6:   return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
            4'd7, 4'd8:   return {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP};
            4'd9, 4'd10:  return {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP};
            4'd11, 4'd12: return {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP};
            // Unsupported lw, sll and mul
            4'd13:        return {imm, rs1, 3'b010, rd, OPC_LOAD};
            4'd14:        return {7'b0000000, rs2, rs1, 3'b001, rd, OPC_OP};
            4'd15:        return {7'b0000001, rs2, rs1, 3'b000, rd, OPC_OP};
            default:      return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
        endcase
    endfunction

    // ----------------------------------------
    // Instruction memory model
    // ----------------------------------------
    always @(posedge clk_i) begin
        logic [31:0] r;
        if (rst_ni) begin
            if (instr_rvalid_i) begin
                instr_rvalid_i <= 1'b0;
            end
            if (instr_req_o && instr_gnt_i) begin
                instr_gnt_i <= 1'b0;
                if (!imem.exists(instr_addr_o)) begin
                    imem[instr_addr_o] = gen_word();
                end
                pend_addr  = instr_addr_o;
                // Zero delays favoured to keep the pipeline full
                r          = $unsigned($random(seed));
                rv_cnt     = r[1:0] & r[5:4];
                gnt_cnt    = r[3:2] & r[7:6];
                rv_pending = 1'b1;
            end else if ((instr_req_o && !instr_gnt_i) || instr_rvalid_i) begin
                // A returning word means the next request starts next cycle
                if (gnt_cnt == 2'd0) begin
                    instr_gnt_i <= 1'b1;
                end else begin
                    gnt_cnt = gnt_cnt - 2'd1;
                end
            end
            if (rv_pending) begin
                if (rv_cnt == 2'd0) begin
                    instr_rvalid_i <= 1'b1;
                    instr_rdata_i  <= imem[pend_addr];
                    rv_pending = 1'b0;
                end else begin
                    rv_cnt = rv_cnt - 2'd1;
                end
            end
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic check_commit();
        logic [31:0] word;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [31:0] imm;
        logic [31:0] expected;
        logic [4:0]  rd;
        logic        supported;
        if (!imem.exists(commit_o.pc)) begin
            $display("Error at %0d ns: commit of pc 0x%08h that was never fetched",
                     $time, commit_o.pc);
            fail_run();
        end else begin
            word      = imem[commit_o.pc];
            rd        = word[11:7];
            src_a     = shadow[word[19:15]];
            src_b     = shadow[word[24:20]];
            imm       = {{20{word[31]}}, word[31:20]};
            supported = 1'b1;
            expected  = '0;
            if (word[6:0] == OPC_OP_IMM && word[14:12] == 3'b000) begin
                expected = src_a + imm;
            end else if (word[6:0] == OPC_OP && word[31:25] == 7'b0000000) begin
                case (word[14:12])
                    3'b000:  expected = src_a + src_b;
                    3'b100:  expected = src_a ^ src_b;
                    3'b110:  expected = src_a | src_b;
                    3'b111:  expected = src_a & src_b;
                    default: supported = 1'b0;
                endcase
            end else if (word[6:0] == OPC_OP && word[31:25] == 7'b0100000
                         && word[14:12] == 3'b000) begin
                expected = src_a - src_b;
            end else begin
                supported = 1'b0;
            end
            assert (commit_o.rd == rd)
                else report_mismatch("commit_o.rd", 32'(commit_o.rd), 32'(rd));
            assert (commit_o.we == (supported && rd != 5'd0))
                else report_mismatch("commit_o.we", 32'(commit_o.we),
                                     32'(supported && rd != 5'd0));
            // Shadow x0 is never written
            if (supported && rd != 5'd0) begin
                assert (commit_o.wdata == expected)
                    else report_mismatch("commit_o.wdata", commit_o.wdata, expected);
                shadow[rd] = expected;
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_ni && commit_valid_o) begin
            check_commit();
            commit_cnt = commit_cnt + 1;
            if (commit_cnt == NUM_COMMITS) begin
                $display("Simulation completed successfully");
                $finish;
            end
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Error at %0d ns: commits stopped after %0d of %0d instructions",
                     $time, commit_cnt, NUM_COMMITS);
            fail_run();
        end
    end

endmodule
